//--- Makefile
# Verilator build and run for the RGB PWM dimmer

TOP = rgb_pwm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -f rgb_pwm.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "Test passed" sim.log; then \
		echo "Simulation ended without a pass"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- design/load_debounce.sv
`timescale 1ns/1ps

module load_debounce (
    input  logic clk_1k,
    input  logic rst_n,
    input  logic btn,
    output logic load_pulse
);
    import rgb_pwm_pkg::*;

    // Two-flop synchronizer for the raw button
    logic btn_s1;
    logic btn_s2;

    // Filter state
    logic [STABLE_W-1:0] stable_cnt;
    logic                btn_level;
    logic                btn_level_d;

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            btn_s1 <= 1'b0;
            btn_s2 <= 1'b0;
        end else begin
            btn_s1 <= btn;
            btn_s2 <= btn_s1;
        end
    end

    ////////////////////////////////////////
    // Bounce filter
    ////////////////////////////////////////

    // Count cycles the synchronized level differs from the accepted one
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            stable_cnt <= '0;
            btn_level  <= 1'b0;
        end else if (btn_s2 == btn_level) begin
            // Level back where it was so start over
            stable_cnt <= '0;
        end else if (stable_cnt == STABLE_W'(STABLE_TICKS - 1)) begin
            // Held long enough
            btn_level  <= btn_s2;
            stable_cnt <= '0;
        end else begin
            stable_cnt <= stable_cnt + 1'b1;
        end
    end

    // Previous accepted level for edge detect
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            btn_level_d <= 1'b0;
        end else begin
            btn_level_d <= btn_level;
        end
    end

    // One cycle per accepted press
    assign load_pulse = btn_level & ~btn_level_d;

    // A pulse needs the synchronized level high a full stable run earlier
    a_filter_length: assert property (@(posedge clk_1k) disable iff (!rst_n)
        load_pulse |-> $past(btn_s2, STABLE_TICKS));

endmodule

//--- design/pwm_rgb_compare.sv
`timescale 1ns/1ps

module pwm_rgb_compare (
    input  logic                  clk_1k,
    input  logic                  rst_n,
    input  rgb_pwm_pkg::setting_t cnt,
    input  logic                  frame_wrap,
    input  rgb_pwm_pkg::setting_t duty_r,
    input  rgb_pwm_pkg::setting_t duty_g,
    input  rgb_pwm_pkg::setting_t duty_b,
    output logic                  rgb_r,
    output logic                  rgb_g,
    output logic                  rgb_b
);
    import rgb_pwm_pkg::*;

    // Index 0 red, 1 green, 2 blue
    localparam int COLOURS = 3;

    setting_t           duty_in [COLOURS];
    setting_t           duty_shadow [COLOURS];
    logic [COLOURS-1:0] rgb_n;

    assign duty_in[0] = duty_r;
    assign duty_in[1] = duty_g;
    assign duty_in[2] = duty_b;

    ////////////////////////////////////////
    // Duty shadows
    ////////////////////////////////////////

    // Duties change only between frames in step with the period
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < COLOURS; i++) begin
                duty_shadow[i] <= DUTY_DEFAULT;
            end
        end else if (frame_wrap) begin
            for (int i = 0; i < COLOURS; i++) begin
                duty_shadow[i] <= duty_in[i];
            end
        end
    end

    ////////////////////////////////////////
    // Compare and drive
    ////////////////////////////////////////

    // Low is lit and registered so the pins never glitch
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            rgb_n <= '1;
        end else begin
            for (int i = 0; i < COLOURS; i++) begin
                rgb_n[i] <= ~(cnt < duty_shadow[i]);
            end
        end
    end

    assign rgb_r = rgb_n[0];
    assign rgb_g = rgb_n[1];
    assign rgb_b = rgb_n[2];

endmodule

//--- design/pwm_timebase.sv
`timescale 1ns/1ps

module pwm_timebase (
    input  logic                  clk_1k,
    input  logic                  rst_n,
    input  rgb_pwm_pkg::setting_t period,
    output rgb_pwm_pkg::setting_t cnt,
    output logic                  frame_wrap
);
    import rgb_pwm_pkg::*;

    // Period in force for the current frame
    setting_t period_shadow;

    // Last cycle of the frame
    assign frame_wrap = (cnt == period_shadow);

    ////////////////////////////////////////
    // Frame counter
    ////////////////////////////////////////

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (frame_wrap) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // New period only takes effect at a frame boundary
    // so a mid-frame load never bends the current frame
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            period_shadow <= RES_DEFAULT;
        end else if (frame_wrap) begin
            period_shadow <= period;
        end
    end

    // Count stays inside the frame even as the period changes
    a_cnt_in_frame: assert property (@(posedge clk_1k) disable iff (!rst_n)
        cnt <= period_shadow);

endmodule

//--- design/rgb_pwm_pkg.sv
package rgb_pwm_pkg;

    ////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////

    // Switch byte and every stored setting
    localparam int DATA_W = 8;

    // Period and duty values share one type
    typedef logic [DATA_W-1:0] setting_t;

    ////////////////////////////////////////
    // Load slots
    ////////////////////////////////////////

    // Write target in load order
    typedef enum logic [1:0] {
        SLOT_RES   = 2'd0,
        SLOT_RED   = 2'd1,
        SLOT_GREEN = 2'd2,
        SLOT_BLUE  = 2'd3
    } slot_t;

    // Width of the one-hot slot indicator
    localparam int SLOT_N = 4;

    ////////////////////////////////////////
    // Debounce and reset values
    ////////////////////////////////////////

    // Cycles a synchronized level must hold
    localparam int STABLE_TICKS = 20;
    // Stable counter runs 0 .. STABLE_TICKS-1
    localparam int STABLE_W = $clog2(STABLE_TICKS);

    // 64-cycle frame out of reset
    localparam setting_t RES_DEFAULT  = setting_t'(63);
    // All colours dark out of reset
    localparam setting_t DUTY_DEFAULT = setting_t'(0);

endpackage

//--- design/rgb_pwm_top.sv
`timescale 1ns/1ps

module rgb_pwm_top (
    input  logic                           clk_1k,
    input  logic                           rst_n,
    input  logic                           btn_load,
    input  rgb_pwm_pkg::setting_t          sw,
    output logic [rgb_pwm_pkg::SLOT_N-1:0] led,
    output logic                           rgb_r,
    output logic                           rgb_g,
    output logic                           rgb_b
);
    import rgb_pwm_pkg::*;

    // Stored settings from the loader
    setting_t period;
    setting_t duty_r;
    setting_t duty_g;
    setting_t duty_b;

    // Shared timebase
    setting_t cnt;
    logic     frame_wrap;

    ////////////////////////////////////////
    // Settings loader
    ////////////////////////////////////////

    slot_loader slot_loader_i (
        .clk_1k   (clk_1k),
        .rst_n    (rst_n),
        .btn_load (btn_load),
        .sw       (sw),
        .led      (led),
        .period   (period),
        .duty_r   (duty_r),
        .duty_g   (duty_g),
        .duty_b   (duty_b)
    );

    ////////////////////////////////////////
    // PWM path
    ////////////////////////////////////////

    pwm_timebase pwm_timebase_i (
        .clk_1k     (clk_1k),
        .rst_n      (rst_n),
        .period     (period),
        .cnt        (cnt),
        .frame_wrap (frame_wrap)
    );

    // Active-low RGB pins
    pwm_rgb_compare pwm_rgb_compare_i (
        .clk_1k     (clk_1k),
        .rst_n      (rst_n),
        .cnt        (cnt),
        .frame_wrap (frame_wrap),
        .duty_r     (duty_r),
        .duty_g     (duty_g),
        .duty_b     (duty_b),
        .rgb_r      (rgb_r),
        .rgb_g      (rgb_g),
        .rgb_b      (rgb_b)
    );

endmodule

//--- design/slot_loader.sv
`timescale 1ns/1ps

module slot_loader (
    input  logic                           clk_1k,
    input  logic                           rst_n,
    input  logic                           btn_load,
    input  rgb_pwm_pkg::setting_t          sw,
    output logic [rgb_pwm_pkg::SLOT_N-1:0] led,
    output rgb_pwm_pkg::setting_t          period,
    output rgb_pwm_pkg::setting_t          duty_r,
    output rgb_pwm_pkg::setting_t          duty_g,
    output rgb_pwm_pkg::setting_t          duty_b
);
    import rgb_pwm_pkg::*;

    logic              load_pulse;
    slot_t             slot;
    logic [SLOT_N-1:0] slot_onehot;

    // Clean one-cycle load strobe
    load_debounce load_debounce_i (
        .clk_1k     (clk_1k),
        .rst_n      (rst_n),
        .btn        (btn_load),
        .load_pulse (load_pulse)
    );

    ////////////////////////////////////////
    // Slot sequencer
    ////////////////////////////////////////

    // Advance once per press and wrap after blue
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            slot <= SLOT_RES;
        end else if (load_pulse) begin
            case (slot)
                SLOT_RES:   slot <= SLOT_RED;
                SLOT_RED:   slot <= SLOT_GREEN;
                SLOT_GREEN: slot <= SLOT_BLUE;
                default:    slot <= SLOT_RES;
            endcase
        end
    end

    // One-hot decode for the board LEDs
    always_comb begin
        slot_onehot       = '0;
        slot_onehot[slot] = 1'b1;
    end

    assign led = slot_onehot;

    ////////////////////////////////////////
    // Setting registers
    ////////////////////////////////////////

    // Only the slot under the pointer takes the switches
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            period <= RES_DEFAULT;
            duty_r <= DUTY_DEFAULT;
            duty_g <= DUTY_DEFAULT;
            duty_b <= DUTY_DEFAULT;
        end else if (load_pulse) begin
            case (slot)
                SLOT_RES:   period <= sw;
                SLOT_RED:   duty_r <= sw;
                SLOT_GREEN: duty_g <= sw;
                default:    duty_b <= sw;
            endcase
        end
    end

    // Each press moves the lit indicator one place up, blue back to period
    a_led_rotate: assert property (@(posedge clk_1k) disable iff (!rst_n)
        load_pulse |=> led == {$past(led[SLOT_N-2:0]), $past(led[SLOT_N-1])});

endmodule

//--- dv/rgb_pwm_tb.sv
`timescale 1ns/1ps

module rgb_pwm_tb;
    import rgb_pwm_pkg::*;

    ////////////////////////////////////////
    // Run constants
    ////////////////////////////////////////

    localparam int SEED          = 32'hf231;
    localparam int HALF_PERIOD   = 20;
    localparam int RESET_CYCLES  = 3;
    // Button held and released this long for a clean press
    localparam int HOLD_CYCLES   = 30;
    localparam int RANDOM_ROUNDS = 8;
    // Fixed corner rounds with one at period 0
    localparam int FIXED_ROUNDS  = 2;
    // Four presses plus three 256-cycle spans for each of four settings
    localparam int ROUND_CYCLES  = 4 * 70 + 4 * 256 * 3;
    localparam int CYCLE_LIMIT   = (RANDOM_ROUNDS + FIXED_ROUNDS) * ROUND_CYCLES + 2000;

    // DUT pins
    logic              clk_1k;
    logic              rst_n;
    logic              btn_load;
    setting_t          sw;
    logic [SLOT_N-1:0] led;
    logic              rgb_r;
    logic              rgb_g;
    logic              rgb_b;

    // Reference model holds the next slot and the four stored settings
    // Index 0 period, 1 red, 2 green, 3 blue
    int model_slot;
    int model_set [SLOT_N];

    int cycle_count = 0;

    rgb_pwm_top rgb_pwm_top_i (
        .clk_1k   (clk_1k),
        .rst_n    (rst_n),
        .btn_load (btn_load),
        .sw       (sw),
        .led      (led),
        .rgb_r    (rgb_r),
        .rgb_g    (rgb_g),
        .rgb_b    (rgb_b)
    );

    // 40 ns clock
    initial begin
        clk_1k = 1'b0;
        forever #HALF_PERIOD clk_1k = ~clk_1k;
    end

    // Hard stop if the run never reaches its end
    always @(posedge clk_1k) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run went past %0d clock cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Single comparison point that stops at the first mismatch
    task automatic check_value(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("error: time %0t signal %s expected %0d actual %0d",
                     $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Lit cycles per frame are the duty capped at the frame length
    function automatic int expected_on(input int duty, input int period);
        if (duty > period + 1) begin
            return period + 1;
        end
        return duty;
    endfunction

    // Slot indicator and dark LEDs for a whole frame after reset
    task automatic check_reset_state();
        repeat (int'(RES_DEFAULT) + 1) begin
            @(negedge clk_1k);
            check_value("led", 1, int'(led));
            check_value("rgb_r", 1, int'(rgb_r));
            check_value("rgb_g", 1, int'(rgb_g));
            check_value("rgb_b", 1, int'(rgb_b));
        end
    endtask

    // Pulses that are all too short to pass the filter
    task automatic bounce_burst();
        int pulses;
        int high_len;
        int low_len;
        pulses = $urandom_range(1, 4);
        for (int i = 0; i < pulses; i++) begin
            high_len = $urandom_range(1, STABLE_TICKS - 1);
            low_len  = $urandom_range(1, 10);
            @(posedge clk_1k);
            sw       <= setting_t'($urandom_range(0, 255));
            btn_load <= 1'b1;
            repeat (high_len) @(posedge clk_1k);
            btn_load <= 1'b0;
            repeat (low_len) @(posedge clk_1k);
        end
        // Let the synchronizer and filter drain
        repeat (STABLE_TICKS + 4) @(posedge clk_1k);
        @(negedge clk_1k);
        check_value("led", 1 << model_slot, int'(led));
    endtask

    // One clean press with steady switches
    task automatic press_load(input setting_t value);
        @(posedge clk_1k);
        sw       <= value;
        btn_load <= 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk_1k);
        btn_load <= 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk_1k);
        // Model update wrapping after blue
        model_set[model_slot] = int'(value);
        model_slot = (model_slot + 1) % SLOT_N;
        @(negedge clk_1k);
        check_value("led", 1 << model_slot, int'(led));
    endtask

    // Count lit cycles over whole frames of the model period
    task automatic measure_duty(input int frames);
        int frame_len;
        int on_r;
        int on_g;
        int on_b;
        frame_len = model_set[0] + 1;
        on_r = 0;
        on_g = 0;
        on_b = 0;
        repeat (frames * frame_len) begin
            @(negedge clk_1k);
            if (!rgb_r) on_r++;
            if (!rgb_g) on_g++;
            if (!rgb_b) on_b++;
        end
        check_value("rgb_r", frames * expected_on(model_set[1], model_set[0]), on_r);
        check_value("rgb_g", frames * expected_on(model_set[2], model_set[0]), on_g);
        check_value("rgb_b", frames * expected_on(model_set[3], model_set[0]), on_b);
    endtask

    // Four loads followed by settling and measurement
    task automatic run_round(input setting_t per, input setting_t red,
                             input setting_t green, input setting_t blue,
                             input int frames);
        int prev_period;
        prev_period = model_set[0];
        bounce_burst();
        press_load(per);
        press_load(red);
        press_load(green);
        press_load(blue);
        // Frame in progress may still run on the old period
        // then three frames of the new one
        repeat ((prev_period + 1) + 3 * (model_set[0] + 1)) @(posedge clk_1k);
        measure_duty(frames);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        setting_t per;
        setting_t red;
        setting_t green;
        setting_t blue;
        void'($urandom(SEED));
        rst_n    <= 1'b0;
        btn_load <= 1'b0;
        sw       <= '0;
        model_slot = 0;
        model_set[0] = int'(RES_DEFAULT);
        model_set[1] = int'(DUTY_DEFAULT);
        model_set[2] = int'(DUTY_DEFAULT);
        model_set[3] = int'(DUTY_DEFAULT);

        repeat (RESET_CYCLES) @(posedge clk_1k);
        rst_n <= 1'b1;
        check_reset_state();

        // Random settings from the seed
        for (int i = 0; i < RANDOM_ROUNDS; i++) begin
            per   = setting_t'($urandom_range(0, 255));
            red   = setting_t'($urandom_range(0, 255));
            green = setting_t'($urandom_range(0, 255));
            blue  = setting_t'($urandom_range(0, 255));
            run_round(per, red, green, blue, 1);
        end

        // Dark, duty at period, duty past period
        run_round(setting_t'(20), setting_t'(0), setting_t'(20), setting_t'(200), 4);
        // Single-cycle frame with one dark and two always-lit colours
        run_round(setting_t'(0), setting_t'(0), setting_t'(1), setting_t'(255), 4);

        $display("Test passed");
        $finish;
    end

endmodule

//--- rgb_pwm.f
design/rgb_pwm_pkg.sv
design/load_debounce.sv
design/slot_loader.sv
design/pwm_timebase.sv
design/pwm_rgb_compare.sv
design/rgb_pwm_top.sv
dv/rgb_pwm_tb.sv
